// ==== source/rvIsaPkg.sv ====
`default_nettype none

package rvIsaPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Major opcodes of the supported subset
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opAuipc = 7'b0010111;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    typedef struct packed {
        logic [6:0]          funct7;
        logic [regAddrW-1:0] rs2;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0]         imm;
        logic [regAddrW-1:0] rs1;
        logic [2:0]          funct3;
        logic [regAddrW-1:0] rd;
        logic [6:0]          opcode;
    } iTypeT;

    // Same word, two views
    typedef union packed {
        rTypeT r;
        iTypeT i;
    } insnT;

endpackage

`default_nettype wire

// ==== source/cpuPipePkg.sv ====
`default_nettype none

package cpuPipePkg;

    import rvIsaPkg::*;

    localparam int prefixLevels = $clog2(xlen);

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu,
        aluXor, aluSrl, aluSra, aluOr, aluAnd
    } aluOpT;

    typedef enum logic [1:0] {aSelReg, aSelPc, aSelZero} aSelT;
    typedef enum logic {bSelReg, bSelImm} bSelT;

    typedef struct packed {
        logic [xlen-1:0] pc;
        insnT            insn;
    } ifIdT;

    typedef struct packed {
        logic                regWrite;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
        logic [xlen-1:0]     rs1Data;
        logic [xlen-1:0]     rs2Data;
        logic [xlen-1:0]     imm;
        logic [xlen-1:0]     pc;
        aluOpT               aluOp;
        aSelT                aSel;
        bSelT                bSel;
    } idExT;

    typedef struct packed {
        logic                regWrite;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     result;
    } wbT;

endpackage

`default_nettype wire

// ==== source/prefixAdder.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefixAdder import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  logic            carryIn,
    output logic [xlen-1:0] sum
);

    // Level 0 holds the bitwise terms, the last level the carries out of each bit
    wire [xlen-1:0] gen [0:prefixLevels];
    wire [xlen-1:0] prop [0:prefixLevels-1];
    wire [xlen-1:0] halfSum;

    assign halfSum = a ^ b;
    // Carry-in folded into bit 0 generate
    assign gen[0]  = (a & b) | {{(xlen-1){1'b0}}, halfSum[0] & carryIn};
    assign prop[0] = halfSum;

    for (genvar lvl = 1; lvl <= prefixLevels; lvl++) begin : gLevel
        for (genvar i = 0; i < xlen; i++) begin : gBit
            if (i >= (1 << (lvl - 1))) begin : gCell
                assign gen[lvl][i] = gen[lvl-1][i]
                    | (prop[lvl-1][i] & gen[lvl-1][i - (1 << (lvl - 1))]);
                if (lvl < prefixLevels) begin : gProp
                    assign prop[lvl][i] = prop[lvl-1][i]
                        & prop[lvl-1][i - (1 << (lvl - 1))];
                end
            end else begin : gPass
                assign gen[lvl][i] = gen[lvl-1][i];
                if (lvl < prefixLevels) begin : gProp
                    assign prop[lvl][i] = prop[lvl-1][i];
                end
            end
        end
    end

    // Carry into bit i is the group generate of bits i-1 down to 0
    assign sum = halfSum ^ {gen[prefixLevels][xlen-2:0], carryIn};

endmodule

`default_nettype wire

// ==== source/fetchStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetchStage import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic [xlen-1:0] imemInsn,
    output logic [xlen-1:0] imemAddr,
    output ifIdT            ifId
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] pcNext;

    prefixAdder pcIncrement (
        .a       (pc),
        .b       (xlen'(4)),
        .carryIn (1'b0),
        .sum     (pcNext)
    );

    // No branches, so the PC only ever moves forward
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc   <= '0;
            ifId <= '0;
        end else begin
            pc        <= pcNext;
            ifId.pc   <= pc;
            ifId.insn <= imemInsn;
        end
    end

    assign imemAddr = pc;

endmodule

`default_nettype wire

// ==== source/registerFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerFile import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    output logic [xlen-1:0]     rs1Data,
    output logic [xlen-1:0]     rs2Data,
    input  wbT                  wr
);

    // x0 is not stored
    logic [xlen-1:0] regs [1:31];

    function automatic logic [xlen-1:0] readReg(input logic [regAddrW-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        // Write-through for the value landing this cycle
        if (wr.regWrite && wr.rd == addr) begin
            return wr.result;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.regWrite && wr.rd != '0) begin
            regs[wr.rd] <= wr.result;
        end
    end

    always_comb begin
        rs1Data = readReg(rs1);
        rs2Data = readReg(rs2);
    end

endmodule

`default_nettype wire

// ==== source/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeStage import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  ifIdT ifId,
    input  wbT   wr,
    output idExT idEx
);

    insnT            insn;
    logic            regWrite;
    aluOpT           aluOp;
    aSelT            aSel;
    bSelT            bSel;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;

    assign insn = ifId.insn;

    registerFile regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1     (insn.r.rs1),
        .rs2     (insn.r.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wr      (wr)
    );

    always_comb begin
        regWrite = 1'b0;
        aluOp    = aluAdd;
        aSel     = aSelReg;
        bSel     = bSelReg;
        imm      = '0;
        case (insn.r.opcode)
            opOp: begin
                regWrite = 1'b1;
                case (insn.r.funct3)
                    f3AddSub: aluOp = insn.r.funct7[5] ? aluSub : aluAdd;
                    f3Sll:    aluOp = aluSll;
                    f3Slt:    aluOp = aluSlt;
                    f3Sltu:   aluOp = aluSltu;
                    f3Xor:    aluOp = aluXor;
                    f3SrlSra: aluOp = insn.r.funct7[5] ? aluSra : aluSrl;
                    f3Or:     aluOp = aluOr;
                    default:  aluOp = aluAnd;
                endcase
            end
            opOpImm: begin
                regWrite = 1'b1;
                bSel     = bSelImm;
                imm      = {{(xlen-12){insn.i.imm[11]}}, insn.i.imm};
                case (insn.i.funct3)
                    f3AddSub: aluOp = aluAdd;
                    f3Slt:    aluOp = aluSlt;
                    f3Sltu:   aluOp = aluSltu;
                    f3Xor:    aluOp = aluXor;
                    f3Or:     aluOp = aluOr;
                    f3And:    aluOp = aluAnd;
                    f3Sll: begin
                        aluOp = aluSll;
                        imm   = {{(xlen-5){1'b0}}, insn.i.imm[4:0]};
                    end
                    default: begin
                        // imm[10] is instruction bit 30
                        aluOp = insn.i.imm[10] ? aluSra : aluSrl;
                        imm   = {{(xlen-5){1'b0}}, insn.i.imm[4:0]};
                    end
                endcase
            end
            opLui, opAuipc: begin
                regWrite = 1'b1;
                aSel     = (insn.r.opcode == opLui) ? aSelZero : aSelPc;
                bSel     = bSelImm;
                imm      = {insn[31:12], 12'b0};
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else begin
            idEx.regWrite <= regWrite;
            idEx.rd       <= insn.r.rd;
            idEx.rs1      <= insn.r.rs1;
            idEx.rs2      <= insn.r.rs2;
            idEx.rs1Data  <= rs1Data;
            idEx.rs2Data  <= rs2Data;
            idEx.imm      <= imm;
            idEx.pc       <= ifId.pc;
            idEx.aluOp    <= aluOp;
            idEx.aSel     <= aSel;
            idEx.bSel     <= bSel;
        end
    end

endmodule

`default_nettype wire

// ==== source/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic [xlen-1:0] a,
    input  logic [xlen-1:0] b,
    input  aluOpT           op,
    output logic [xlen-1:0] y
);

    logic            subtract;
    logic [xlen-1:0] bOperand;
    logic [xlen-1:0] sum;
    logic            carryOut;
    logic            overflow;
    logic            lessSigned;

    // Compares run through the subtractor as well
    assign subtract = (op == aluSub) || (op == aluSlt) || (op == aluSltu);
    assign bOperand = subtract ? ~b : b;

    prefixAdder adder (
        .a       (a),
        .b       (bOperand),
        .carryIn (subtract),
        .sum     (sum)
    );

    // MSB carry rebuilt from the carry into the top bit
    assign carryOut = (a[xlen-1] & bOperand[xlen-1])
        | ((a[xlen-1] | bOperand[xlen-1]) & (sum[xlen-1] ^ a[xlen-1] ^ bOperand[xlen-1]));
    assign overflow   = (a[xlen-1] == bOperand[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign lessSigned = sum[xlen-1] ^ overflow;

    always_comb begin
        case (op)
            aluAdd,
            aluSub:  y = sum;
            aluSll:  y = a << b[4:0];
            aluSlt:  y = {{(xlen-1){1'b0}}, lessSigned};
            // No carry out of a - b means a borrowed
            aluSltu: y = {{(xlen-1){1'b0}}, ~carryOut};
            aluXor:  y = a ^ b;
            aluSrl:  y = a >> b[4:0];
            aluSra:  y = $unsigned($signed(a) >>> b[4:0]);
            aluOr:   y = a | b;
            aluAnd:  y = a & b;
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/executeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module executeStage import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  idExT idEx,
    output wbT   exWb
);

    logic            fwdRs1;
    logic            fwdRs2;
    logic [xlen-1:0] src1;
    logic [xlen-1:0] src2;
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluY;

    // Result of the previous instruction is still in exWb
    assign fwdRs1 = exWb.regWrite && (idEx.rs1 != '0) && (exWb.rd == idEx.rs1);
    assign fwdRs2 = exWb.regWrite && (idEx.rs2 != '0) && (exWb.rd == idEx.rs2);

    assign src1 = fwdRs1 ? exWb.result : idEx.rs1Data;
    assign src2 = fwdRs2 ? exWb.result : idEx.rs2Data;

    always_comb begin
        case (idEx.aSel)
            aSelPc:   opA = idEx.pc;
            aSelZero: opA = '0;
            default:  opA = src1;
        endcase
    end

    assign opB = (idEx.bSel == bSelImm) ? idEx.imm : src2;

    alu alu (
        .a  (opA),
        .b  (opB),
        .op (idEx.aluOp),
        .y  (aluY)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exWb <= '0;
        end else begin
            // Writes to x0 are dropped here so nothing downstream sees them
            exWb.regWrite <= idEx.regWrite && (idEx.rd != '0);
            exWb.rd       <= idEx.rd;
            exWb.result   <= aluY;
        end
    end

endmodule

`default_nettype wire

// ==== source/riscvCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCore import rvIsaPkg::*, cpuPipePkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] imemAddr,
    input  logic [xlen-1:0] imemInsn,
    output wbT              wb
);

    ifIdT ifId;
    idExT idEx;
    wbT   exWb;

    fetchStage fetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .imemInsn (imemInsn),
        .imemAddr (imemAddr),
        .ifId     (ifId)
    );

    // Execute result also feeds the register-file write port
    decodeStage decode (
        .clk   (clk),
        .rst_n (rst_n),
        .ifId  (ifId),
        .wr    (exWb),
        .idEx  (idEx)
    );

    executeStage execute (
        .clk   (clk),
        .rst_n (rst_n),
        .idEx  (idEx),
        .exWb  (exWb)
    );

    assign wb = exWb;

endmodule

`default_nettype wire

// ==== test/isaModel.svh ====
// Instruction encoders
function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, opOp};
endfunction

function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, opOpImm};
endfunction

function automatic logic [31:0] upperWord(input logic [6:0] op, input logic [19:0] imm,
                                          input logic [4:0] rd);
    return {imm, rd, op};
endfunction

// True when the word is a supported op with a nonzero rd
function automatic logic writesReg(input logic [31:0] w);
    logic supported;
    supported = (w[6:0] == opOp) || (w[6:0] == opOpImm)
        || (w[6:0] == opLui) || (w[6:0] == opAuipc);
    return supported && (w[11:7] != 5'd0);
endfunction

// Result per the ISA definition, given the source register values
function automatic logic [31:0] isaResult(input logic [31:0] w, input logic [31:0] pc,
                                          input logic [31:0] r1, input logic [31:0] r2);
    logic [31:0] b;
    logic [4:0]  sh;
    if (w[6:0] == opLui) begin
        return {w[31:12], 12'b0};
    end
    if (w[6:0] == opAuipc) begin
        return pc + {w[31:12], 12'b0};
    end
    b = (w[6:0] == opOp) ? r2 : {{20{w[31]}}, w[31:20]};
    sh = b[4:0];
    case (w[14:12])
        3'd0: return (w[6:0] == opOp && w[30]) ? r1 - b : r1 + b;
        3'd1: return r1 << sh;
        3'd2: return ($signed(r1) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (r1 < b) ? 32'd1 : 32'd0;
        3'd4: return r1 ^ b;
        3'd5: return w[30] ? $unsigned($signed(r1) >>> sh) : r1 >> sh;
        3'd6: return r1 | b;
        default: return r1 & b;
    endcase
endfunction

// ==== test/riscvCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module riscvCoreTb import rvIsaPkg::*, cpuPipePkg::*; ();

    localparam int progMax = 256;
    localparam int drainLimit = 1000;

    logic        clk;
    logic        rst_n;
    logic [31:0] imemAddr;
    logic [31:0] imemInsn;
    wbT          wb;

    logic [31:0] progMem [0:progMax-1];
    int          progLen;
    logic        expWr [0:progMax-1];
    logic [4:0]  expRd [0:progMax-1];
    logic [31:0] expVal [0:progMax-1];
    logic [31:0] modelRegs [0:31];
    logic [31:0] rngState;
    int          wrErrors;
    int          rdErrors;
    int          valErrors;
    int          addrErrors;
    int          timeouts;

    `include "isaModel.svh"

    riscvCore DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .imemAddr (imemAddr),
        .imemInsn (imemInsn),
        .wb       (wb)
    );

    function automatic logic [31:0] nextRandom();
        rngState = rngState * 32'd1664525 + 32'd1013904223;
        return rngState;
    endfunction

    task automatic addInsn(input logic [31:0] w);
        progMem[progLen] = w;
        progLen++;
    endtask

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        return (int'(addr >> 2) < progLen) ? progMem[addr >> 2] : 32'd0;
    endfunction

    // Instruction whose write is due when the PC shows addr
    function automatic int dueIndex(input logic [31:0] addr);
        return int'(addr >> 2) - 3;
    endfunction

    function automatic logic dueWrite(input logic [31:0] addr);
        int k;
        k = dueIndex(addr);
        return (k >= 0 && k < progLen) ? expWr[k] : 1'b0;
    endfunction

    function automatic logic [4:0] dueRd(input logic [31:0] addr);
        return expRd[dueIndex(addr)];
    endfunction

    function automatic logic [31:0] dueVal(input logic [31:0] addr);
        return expVal[dueIndex(addr)];
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        #1 imemInsn <= fetchWord(imemAddr);
    end

    resetQuiet: assert property (@(posedge clk) !rst_n |-> !wb.regWrite)
        else begin
            wrErrors++;
            $display("CHECK FAILED time=%0t signal=wb.regWrite expected=0 actual=1", $time);
        end

    addrAtRelease: assert property (@(posedge clk) $rose(rst_n) |-> imemAddr == 32'd0)
        else begin
            addrErrors++;
            $display("CHECK FAILED time=%0t signal=imemAddr expected=00000000 actual=%h",
                     $time, $sampled(imemAddr));
        end

    addrStep: assert property (@(posedge clk) disable iff (!rst_n)
                               $past(rst_n) |-> imemAddr == $past(imemAddr) + 32'd4)
        else begin
            addrErrors++;
            $display("CHECK FAILED time=%0t signal=imemAddr expected=%h actual=%h",
                     $time, $past(imemAddr) + 32'd4, $sampled(imemAddr));
        end

    wbEvent: assert property (@(posedge clk) disable iff (!rst_n)
                              wb.regWrite == dueWrite(imemAddr))
        else begin
            wrErrors++;
            $display("CHECK FAILED time=%0t signal=wb.regWrite expected=%b actual=%b",
                     $time, dueWrite($sampled(imemAddr)), $sampled(wb.regWrite));
        end

    wbRd: assert property (@(posedge clk) disable iff (!rst_n)
                           dueWrite(imemAddr) |-> wb.rd == dueRd(imemAddr))
        else begin
            rdErrors++;
            $display("CHECK FAILED time=%0t signal=wb.rd expected=%0d actual=%0d",
                     $time, dueRd($sampled(imemAddr)), $sampled(wb.rd));
        end

    wbResult: assert property (@(posedge clk) disable iff (!rst_n)
                               dueWrite(imemAddr) |-> wb.result == dueVal(imemAddr))
        else begin
            valErrors++;
            $display("CHECK FAILED time=%0t signal=wb.result expected=%h actual=%h",
                     $time, dueVal($sampled(imemAddr)), $sampled(wb.result));
        end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] w;
        logic [6:0]  f7;
        logic [11:0] imm;
        int          cycles;
        rst_n = 1'b0;
        imemInsn = 32'd0;
        progLen = 0;
        rngState = 32'hffc9;
        wrErrors = 0;
        rdErrors = 0;
        valErrors = 0;
        addrErrors = 0;
        timeouts = 0;

        // Negative immediates, SLTIU, SRAI against SRLI
        addInsn(iTypeWord(12'hffb, 5'd0, f3AddSub, 5'd1));
        addInsn(iTypeWord(12'hfff, 5'd1, f3Sltu, 5'd2));
        addInsn(iTypeWord(12'h802, 5'd0, f3Slt, 5'd3));
        addInsn(iTypeWord(12'h402, 5'd1, f3SrlSra, 5'd4));
        addInsn(iTypeWord(12'h002, 5'd1, f3SrlSra, 5'd5));
        addInsn(iTypeWord(12'hf0f, 5'd1, f3Xor, 5'd6));
        addInsn(iTypeWord(12'h81f, 5'd0, f3Or, 5'd7));
        addInsn(iTypeWord(12'h01f, 5'd7, f3Sll, 5'd3));
        // Upper immediates and x0
        addInsn(upperWord(opLui, 20'hdead1, 5'd1));
        addInsn(upperWord(opAuipc, 20'h00012, 5'd2));
        addInsn(iTypeWord(12'h055, 5'd1, f3AddSub, 5'd0));
        addInsn(rTypeWord(7'h00, 5'd0, 5'd0, f3Or, 5'd3));
        addInsn(rTypeWord(7'h00, 5'd0, 5'd1, f3AddSub, 5'd4));
        // Back-to-back dependency chain
        for (int i = 0; i < 6; i++) begin
            addInsn(iTypeWord(12'h123, 5'd4, f3AddSub, 5'd4));
        end
        addInsn(rTypeWord(7'h20, 5'd4, 5'd4, f3AddSub, 5'd5));
        // Reads two instructions back through the register file
        addInsn(iTypeWord(12'h007, 5'd0, f3AddSub, 5'd6));
        addInsn(iTypeWord(12'h009, 5'd0, f3AddSub, 5'd7));
        addInsn(rTypeWord(7'h00, 5'd0, 5'd6, f3Xor, 5'd1));
        addInsn(rTypeWord(7'h00, 5'd1, 5'd7, f3Sll, 5'd2));
        // Unsupported words between live instructions
        addInsn(32'd0);
        addInsn(32'h00002083);
        addInsn(rTypeWord(7'h00, 5'd2, 5'd1, f3Sltu, 5'd3));
        addInsn(32'h0000000f);
        addInsn(rTypeWord(7'h00, 5'd3, 5'd1, f3And, 5'd4));

        // Random mix over x0..x7
        for (int n = 0; n < 80; n++) begin
            r = nextRandom();
            r2 = nextRandom();
            if (r[24:21] < 4'd7) begin
                f7 = (r[20] && (r[19:17] == f3AddSub || r[19:17] == f3SrlSra)) ? 7'h20 : 7'h00;
                w = rTypeWord(f7, {2'b0, r[16:14]}, {2'b0, r[13:11]}, r[19:17], {2'b0, r[10:8]});
            end else if (r[24:21] < 4'd13) begin
                imm = r2[31:20];
                if (r[19:17] == f3Sll) begin
                    imm = {7'h00, r2[24:20]};
                end else if (r[19:17] == f3SrlSra) begin
                    imm = {r[20] ? 7'h20 : 7'h00, r2[24:20]};
                end
                w = iTypeWord(imm, {2'b0, r[13:11]}, r[19:17], {2'b0, r[10:8]});
            end else if (r[24:21] == 4'd13) begin
                w = upperWord(opLui, r2[31:12], {2'b0, r[10:8]});
            end else if (r[24:21] == 4'd14) begin
                w = upperWord(opAuipc, r2[31:12], {2'b0, r[10:8]});
            end else begin
                w = {r2[31:7], 7'b0000011};
            end
            addInsn(w);
        end

        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = 32'd0;
        end
        for (int i = 0; i < progLen; i++) begin
            w = progMem[i];
            expWr[i] = writesReg(w);
            expRd[i] = w[11:7];
            expVal[i] = isaResult(w, 32'(i * 4), modelRegs[w[19:15]], modelRegs[w[24:20]]);
            if (expWr[i]) begin
                modelRegs[w[11:7]] = expVal[i];
            end
        end

        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        cycles = 0;
        while (imemAddr < 32'((progLen + 5) * 4) && cycles < drainLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (cycles >= drainLimit) begin
            timeouts++;
            $display("Timed out waiting for the program to drain from the pipeline");
        end
        @(posedge clk);

        $display("Errors: writeback %0d, rd %0d, result %0d, address %0d, timeout %0d",
                 wrErrors, rdErrors, valErrors, addrErrors, timeouts);
        if (wrErrors + rdErrors + valErrors + addrErrors + timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+test
source/rvIsaPkg.sv
source/cpuPipePkg.sv
source/prefixAdder.sv
source/fetchStage.sv
source/registerFile.sv
source/decodeStage.sv
source/alu.sv
source/executeStage.sv
source/riscvCore.sv
test/riscvCoreTb.sv

// ==== Bender.yml ====
package:
  name: riscv_core

sources:
  - files:
      - source/rvIsaPkg.sv
      - source/cpuPipePkg.sv
      - source/prefixAdder.sv
      - source/fetchStage.sv
      - source/registerFile.sv
      - source/decodeStage.sv
      - source/alu.sv
      - source/executeStage.sv
      - source/riscvCore.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/riscvCoreTb.sv
